// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = image_filter_tb
FILELIST = image_filter.f
BUILD    = obj_dir
LOG      = sim.log

SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BINARY   = $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BINARY)
	./$(BINARY) 2>&1 | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dv/image_filter_tb.sv
/*
  testbench for the pixel filter on a 4 x 3 raster
  table pixels go one at a time with blanking between, fillers back to back
  stops at the first error, expected values come from the filter rules
*/
`timescale 1ns/100ps
`include "image_filter_params.svh"

module image_filter_tb
    import image_filter_pkg::*;
();

    localparam int HALF_PERIOD    = 50;
    localparam int LINE_PIXELS    = 4;
    localparam int FRAME_LINES    = 3;
    localparam int NUM_ROWS       = 18;
    localparam int OUT_TIMEOUT    = 10;
    localparam int POLL_TIMEOUT   = 40;
    localparam int STREAM_TIMEOUT = 150;

    typedef struct packed {
        filter_mode_e mode;
        pixel_t       step;
        rgb_pixel_t   pixel;
        gray_window_t window;
        logic         rand_win;
        rgb_out_t     expected;
    } table_row_t;

    typedef struct packed {
        logic      valid;
        rgb_out_t  rgb;
        position_t pos;
    } out_entry_t;

    logic         clock = 1'b0;
    logic         reset;
    apb_req_t     apb_req;
    apb_rsp_t     apb_rsp;
    logic         pixel_valid_i;
    rgb_pixel_t   pixel_i;
    gray_window_t window_i;
    rgb_out_t     rgb_o;
    position_t    position_o;
    logic         out_valid_o;

    table_row_t   rows [NUM_ROWS];
    logic [31:0]  rng_state;
    logic         stop_stream;
    // reference model state
    filter_mode_e cur_mode;
    filter_mode_e pend_mode;
    logic         mode_waiting;
    pixel_t       cur_step;
    int           model_hc;
    int           model_vc;

    image_filter_top #(
        .line_pixels (LINE_PIXELS),
        .frame_lines (FRAME_LINES)
    ) i_image_filter_top (
        .clock         (clock),
        .reset         (reset),
        .apb_i         (apb_req),
        .apb_o         (apb_rsp),
        .pixel_valid_i (pixel_valid_i),
        .pixel_i       (pixel_i),
        .window_i      (window_i),
        .rgb_o         (rgb_o),
        .position_o    (position_o),
        .out_valid_o   (out_valid_o)
    );

    always #(HALF_PERIOD) clock = ~clock;

    ////////////////////////////////
    // reference model
    ////////////////////////////////

    function automatic int clamp_byte(input int v);
        if (v < 0) begin
            return 0;
        end else if (v > 255) begin
            return 255;
        end
        return v;
    endfunction

    function automatic rgb_out_t model_pixel(input filter_mode_e mode, input pixel_t step,
                                             input rgb_pixel_t pix, input gray_window_t win);
        int       ch [3];
        int       grey;
        int       cross_sum;
        int       diag;
        rgb_out_t res;
        ch[0] = int'(pix.red);
        ch[1] = int'(pix.green);
        ch[2] = int'(pix.blue);
        cross_sum = int'(win.up) + int'(win.down) + int'(win.left) + int'(win.right);
        diag  = int'(win.left_up) + int'(win.left_down) + int'(win.right_up)
              + int'(win.right_down);
        case (mode)
            MODE_GRAY: grey = ch[0] / 4 + ch[0] / 32 + ch[1] / 2 + ch[1] / 16
                            + ch[2] / 16 + ch[2] / 32;
            MODE_BOX_BLUR: grey = (int'(win.center) + cross_sum + diag) / 9;
            MODE_EDGE: grey = clamp_byte(8 * int'(win.center) - cross_sum - diag);
            MODE_SHARPEN: grey = clamp_byte(5 * int'(win.center) - cross_sum);
            default: grey = -1;
        endcase
        for (int i = 0; i < 3; i++) begin
            if (grey >= 0) begin
                ch[i] = grey;
            end else if (mode == MODE_BRIGHTEN) begin
                ch[i] = clamp_byte(ch[i] + int'(step));
            end else if (mode == MODE_DARKEN) begin
                ch[i] = clamp_byte(ch[i] - int'(step));
            end else if (mode == MODE_INVERT) begin
                ch[i] = 255 - ch[i];
            end
        end
        // upper nibble of each channel
        res.red   = chan_out_t'(ch[0] / 16);
        res.green = chan_out_t'(ch[1] / 16);
        res.blue  = chan_out_t'(ch[2] / 16);
        return res;
    endfunction

    function automatic position_t model_position();
        position_t pos;
        pos.hc = coord_t'(model_hc);
        pos.vc = coord_t'(model_vc);
        return pos;
    endfunction

    // raster step for one valid pixel
    task automatic advance_model();
        if (model_hc == LINE_PIXELS - 1) begin
            model_hc = 0;
            if (model_vc == FRAME_LINES - 1) begin
                model_vc = 0;
                // pending mode starts with the next frame
                if (mode_waiting) begin
                    cur_mode     = pend_mode;
                    mode_waiting = 1'b0;
                end
            end else begin
                model_vc = model_vc + 1;
            end
        end else begin
            model_hc = model_hc + 1;
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic random_pixel(output rgb_pixel_t pix);
        rng_state = xorshift32(rng_state);
        pix = rng_state[23:0];
    endtask

    task automatic random_window(output gray_window_t win);
        logic [31:0] a;
        logic [31:0] b;
        rng_state = xorshift32(rng_state);
        a = rng_state;
        rng_state = xorshift32(rng_state);
        b = rng_state;
        rng_state = xorshift32(rng_state);
        win = {a, b, rng_state[7:0]};
    endtask

    ////////////////////////////////
    // checks
    ////////////////////////////////

    task automatic report_failure();
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rgb(input rgb_out_t got, input rgb_out_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at time %0t: %s, rgb_o is %h, expected %h", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic check_position(input position_t got, input position_t exp,
                                  input string what);
        if (got !== exp) begin
            $display("** Error at time %0t: %s, position_o is (%0d,%0d), expected (%0d,%0d)",
                     $time, what, got.hc, got.vc, exp.hc, exp.vc);
            report_failure();
        end
    endtask

    task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at time %0t: %s, read %h, expected %h", $time, what, got, exp);
            report_failure();
        end
    endtask

    // outputs of the input driven two falling edges earlier
    task automatic check_output(input out_entry_t e, input string what);
        if (out_valid_o !== e.valid) begin
            $display("** Error at time %0t: %s, out_valid_o is %b, expected %b",
                     $time, what, out_valid_o, e.valid);
            report_failure();
        end
        check_rgb(rgb_o, e.rgb, what);
        check_position(position_o, e.pos, what);
    endtask

    ////////////////////////////////
    // apb and pixel drivers
    ////////////////////////////////

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clock);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clock);
        apb_req.penable = 1'b1;
        @(negedge clock);
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge clock);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwdata  = '0;
        @(negedge clock);
        apb_req.penable = 1'b1;
        // prdata settles within the access cycle
        #(HALF_PERIOD / 2);
        data = apb_rsp.prdata;
        @(negedge clock);
        apb_req = '0;
    endtask

    task automatic read_and_check(input logic [7:0] addr, input logic [31:0] exp,
                                  input string what);
        logic [31:0] data;
        apb_read(addr, data);
        check_reg(data, exp, what);
    endtask

    // one valid pixel, then blanking until it comes out
    task automatic send_pixel(input rgb_pixel_t pix, input gray_window_t win,
                              input rgb_out_t exp, input string what);
        position_t exp_pos;
        position_t hold_pos;
        int        latency;
        exp_pos = model_position();
        @(negedge clock);
        pixel_valid_i = 1'b1;
        pixel_i       = pix;
        window_i      = win;
        advance_model();
        hold_pos = model_position();
        latency = 0;
        do begin
            @(negedge clock);
            pixel_valid_i = 1'b0;
            latency++;
            if (latency > OUT_TIMEOUT) begin
                $display("timeout: out_valid_o never rose for %s", what);
                report_failure();
            end
        end while (!out_valid_o);
        if (latency != 2) begin
            $display("%s came out after %0d cycles instead of 2", what, latency);
            report_failure();
        end
        check_rgb(rgb_o, exp, what);
        check_position(position_o, exp_pos, what);
        @(negedge clock);
        if (out_valid_o !== 1'b0) begin
            $display("** Error at time %0t: out_valid_o stayed high during blanking after %s",
                     $time, what);
            report_failure();
        end
        check_rgb(rgb_o, '0, "blanking");
        check_position(position_o, hold_pos, "blanking");
    endtask

    // back-to-back valid pixels until stop_stream, then blanking
    task automatic stream_fillers();
        out_entry_t   lag_q [$];
        out_entry_t   entry;
        rgb_pixel_t   pix;
        gray_window_t win;
        int           count;
        entry.valid = 1'b0;
        entry.rgb   = '0;
        entry.pos   = model_position();
        lag_q.push_back(entry);
        lag_q.push_back(entry);
        count = 0;
        while (!stop_stream) begin
            if (count >= STREAM_TIMEOUT) begin
                $display("timeout: filler pixels ran %0d cycles without STATUS clearing",
                         count);
                report_failure();
            end
            @(negedge clock);
            check_output(lag_q.pop_front(), "filler pixel");
            random_pixel(pix);
            random_window(win);
            entry.valid = 1'b1;
            entry.rgb   = model_pixel(cur_mode, cur_step, pix, win);
            entry.pos   = model_position();
            lag_q.push_back(entry);
            pixel_valid_i = 1'b1;
            pixel_i       = pix;
            window_i      = win;
            advance_model();
            count++;
            @(posedge clock);
        end
        // drain the pipeline, the last check sees blanking
        repeat (3) begin
            @(negedge clock);
            check_output(lag_q.pop_front(), "filler drain");
            entry.valid = 1'b0;
            entry.rgb   = '0;
            entry.pos   = model_position();
            lag_q.push_back(entry);
            pixel_valid_i = 1'b0;
        end
    endtask

    task automatic poll_status();
        logic [31:0] status;
        int          polls;
        polls  = 0;
        status = 32'd1;
        while (status != 32'd0) begin
            if (polls >= POLL_TIMEOUT) begin
                $display("timeout: STATUS stayed pending after %0d polls", polls);
                report_failure();
            end
            apb_read(`IMF_ADDR_STATUS, status);
            polls++;
        end
        stop_stream = 1'b1;
    endtask

    // old mode runs to the end of the frame
    task automatic change_mode(input filter_mode_e mode);
        apb_write(`IMF_ADDR_MODE, 32'(mode));
        pend_mode    = mode;
        mode_waiting = 1'b1;
        read_and_check(`IMF_ADDR_MODE, 32'(mode), "MODE readback");
        read_and_check(`IMF_ADDR_STATUS, 32'd1, "STATUS after MODE write");
        stop_stream = 1'b0;
        fork
            stream_fillers();
            poll_status();
        join
        if (mode_waiting) begin
            $display("** Error at time %0t: STATUS read 0 before the frame ended", $time);
            report_failure();
        end
        read_and_check(`IMF_ADDR_STATUS, 32'd0, "STATUS after frame end");
    endtask

    task automatic load_table();
        rows[0]  = '{MODE_ORIGINAL, 8'd6, 24'h12ABF3, 72'h0, 1'b0, 12'h1AF};
        rows[1]  = '{MODE_GRAY, 8'd6, 24'h3264C8, 72'h0, 1'b0, 12'h777};
        rows[2]  = '{MODE_GRAY, 8'd6, 24'hFFFFFF, 72'h0, 1'b0, 12'hEEE};
        rows[3]  = '{MODE_BRIGHTEN, 8'd6, 24'h0A79FC, 72'h0, 1'b0, 12'h17F};
        rows[4]  = '{MODE_BRIGHTEN, 8'h40, 24'hBF30C0, 72'h0, 1'b0, 12'hF7F};
        rows[5]  = '{MODE_DARKEN, 8'h40, 24'h40903F, 72'h0, 1'b0, 12'h050};
        rows[6]  = '{MODE_DARKEN, 8'd6, 24'h151605, 72'h0, 1'b0, 12'h010};
        rows[7]  = '{MODE_INVERT, 8'd6, 24'hFFA01E, 72'h0, 1'b0, 12'h05E};
        rows[8]  = '{MODE_BOX_BLUR, 8'd6, 24'h0, 72'h0, 1'b1, 12'h0};
        rows[9]  = '{MODE_BOX_BLUR, 8'd6, 24'h0, 72'h0, 1'b1, 12'h0};
        rows[10] = '{MODE_EDGE, 8'd6, 24'h0, 72'h0, 1'b1, 12'h0};
        rows[11] = '{MODE_EDGE, 8'd6, 24'h0, 72'hFF_00_00_00_00_00_00_00_00, 1'b0, 12'hFFF};
        rows[12] = '{MODE_EDGE, 8'd6, 24'h0, 72'h00_01_01_01_01_01_01_01_01, 1'b0, 12'h000};
        rows[13] = '{MODE_EDGE, 8'd6, 24'h0, 72'h40_30_30_30_30_30_30_30_30, 1'b0, 12'h888};
        rows[14] = '{MODE_SHARPEN, 8'd6, 24'h0, 72'h0, 1'b1, 12'h0};
        rows[15] = '{MODE_SHARPEN, 8'd6, 24'h0, 72'hC0_00_00_00_00_FF_FF_FF_FF, 1'b0, 12'hFFF};
        rows[16] = '{MODE_SHARPEN, 8'd6, 24'h0, 72'h10_40_40_40_40_00_00_00_00, 1'b0, 12'h000};
        rows[17] = '{MODE_ORIGINAL, 8'd6, 24'h5AC30F, 72'h0, 1'b0, 12'h5C0};
    endtask

    ////////////////////////////////
    // main sequence
    ////////////////////////////////

    initial begin
        table_row_t   row;
        rgb_out_t     exp;
        gray_window_t win;
        reset         = 1'b1;
        apb_req       = '0;
        pixel_valid_i = 1'b0;
        pixel_i       = '0;
        window_i      = '0;
        rng_state     = 32'd79330;
        stop_stream   = 1'b0;
        cur_mode      = MODE_ORIGINAL;
        pend_mode     = MODE_ORIGINAL;
        mode_waiting  = 1'b0;
        cur_step      = 8'd6;
        model_hc      = 0;
        model_vc      = 0;
        load_table();
        repeat (10) @(negedge clock);
        reset = 1'b0;

        @(negedge clock);
        check_rgb(rgb_o, '0, "after reset");
        check_position(position_o, '0, "after reset");
        if (out_valid_o !== 1'b0) begin
            $display("** Error at time %0t: out_valid_o is not low after reset", $time);
            report_failure();
        end
        read_and_check(`IMF_ADDR_MODE, 32'd0, "MODE after reset");
        read_and_check(`IMF_ADDR_STEP, 32'd6, "STEP after reset");
        read_and_check(`IMF_ADDR_STATUS, 32'd0, "STATUS after reset");

        for (int i = 0; i < NUM_ROWS; i++) begin
            row = rows[i];
            if (row.mode != cur_mode) begin
                change_mode(row.mode);
            end
            if (row.step != cur_step) begin
                apb_write(`IMF_ADDR_STEP, 32'(row.step));
                cur_step = row.step;
                read_and_check(`IMF_ADDR_STEP, 32'(row.step), "STEP readback");
            end
            win = row.window;
            exp = row.expected;
            if (row.rand_win) begin
                random_window(win);
                exp = model_pixel(row.mode, cur_step, row.pixel, win);
            end
            send_pixel(row.pixel, win, exp, $sformatf("table row %0d", i));
        end

        $display("Everything OK");
        $finish;
    end

endmodule

// File: image_filter.f
+incdir+include
source/image_filter_pkg.sv
source/apb_config_regs.sv
source/frame_mode_fsm.sv
source/pixel_position_counter.sv
source/point_op_unit.sv
source/window_conv_unit.sv
source/output_stage.sv
source/image_filter_top.sv
dv/image_filter_tb.sv

// File: include/image_filter_params.svh
/*
  widths, default frame geometry and register map of the pixel filter
  the frame size macros are defaults only, the counter takes parameters
*/
`ifndef IMAGE_FILTER_PARAMS_SVH
`define IMAGE_FILTER_PARAMS_SVH

// sample and coordinate widths
`define IMF_PIXEL_W      8
`define IMF_OUT_W        4
`define IMF_COORD_W      11

// default raster size
`define IMF_LINE_PIXELS  640
`define IMF_FRAME_LINES  480

`define IMF_STEP_RESET   6

// apb register addresses
`define IMF_ADDR_MODE    8'h00
`define IMF_ADDR_STEP    8'h04
`define IMF_ADDR_STATUS  8'h08

`endif

// File: source/apb_config_regs.sv
/*
  apb slave for mode, brightness step and status
  no wait states and no error response, every transfer ends in its access cycle
  a new mode stays pending until the frame fsm applies it
*/
`timescale 1ns/100ps
`include "image_filter_params.svh"

module apb_config_regs
    import image_filter_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  apb_req_t     apb_i,
    output apb_rsp_t     apb_o,
    input  logic         mode_applied_i,
    output filter_mode_e pending_mode_o,
    output logic         mode_pending_o,
    output pixel_t       step_o
);

    logic access;
    logic wr_en;

    assign access = apb_i.psel & apb_i.penable;
    assign wr_en  = access & apb_i.pwrite;

    always_ff @(posedge clock) begin
        if (reset) begin
            pending_mode_o <= MODE_ORIGINAL;
            step_o         <= pixel_t'(`IMF_STEP_RESET);
            mode_pending_o <= 1'b0;
        end else begin
            if (wr_en && apb_i.paddr == `IMF_ADDR_MODE) begin
                pending_mode_o <= filter_mode_e'(apb_i.pwdata[2:0]);
            end
            if (wr_en && apb_i.paddr == `IMF_ADDR_STEP) begin
                step_o <= apb_i.pwdata[`IMF_PIXEL_W-1:0];
            end
            // a write in the apply cycle keeps the flag set
            if (wr_en && apb_i.paddr == `IMF_ADDR_MODE) begin
                mode_pending_o <= 1'b1;
            end else if (mode_applied_i) begin
                mode_pending_o <= 1'b0;
            end
        end
    end

    // read data during the access cycle
    always_comb begin
        apb_o.prdata = '0;
        if (access && !apb_i.pwrite) begin
            case (apb_i.paddr)
                `IMF_ADDR_MODE:   apb_o.prdata = {29'd0, pending_mode_o};
                `IMF_ADDR_STEP:   apb_o.prdata = {24'd0, step_o};
                `IMF_ADDR_STATUS: apb_o.prdata = {31'd0, mode_pending_o};
                default:          apb_o.prdata = '0;
            endcase
        end
    end

endmodule

// File: source/frame_mode_fsm.sv
/*
  moves the pending mode into the active mode at the end of a frame
  so no frame mixes two filters
*/
`timescale 1ns/100ps

module frame_mode_fsm
    import image_filter_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         mode_pending_i,
    input  filter_mode_e pending_mode_i,
    input  logic         frame_end_i,
    output filter_mode_e active_mode_o,
    output logic         mode_applied_o
);

    frame_state_e state;

    // same edge as the mode copy, so the flag is clear when back in RUN
    assign mode_applied_o = (state == PENDING) && frame_end_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            state         <= RUN;
            active_mode_o <= MODE_ORIGINAL;
        end else begin
            case (state)
                RUN: begin
                    if (mode_pending_i) begin
                        state <= PENDING;
                    end
                end
                PENDING: begin
                    if (frame_end_i) begin
                        active_mode_o <= pending_mode_i;
                        state         <= RUN;
                    end
                end
                default: state <= RUN;
            endcase
        end
    end

endmodule

// File: source/image_filter_pkg.sv
/*
  shared types of the pixel filter
  colour structs keep blue in the upper byte, red in the lower byte
*/
`include "image_filter_params.svh"

package image_filter_pkg;

    typedef logic [`IMF_PIXEL_W-1:0] pixel_t;
    typedef logic [`IMF_OUT_W-1:0] chan_out_t;
    typedef logic [`IMF_COORD_W-1:0] coord_t;
    // holds +-8*255
    typedef logic signed [12:0] conv_sum_t;

    typedef enum logic [2:0] {
        MODE_ORIGINAL = 3'd0,
        MODE_GRAY     = 3'd1,
        MODE_BRIGHTEN = 3'd2,
        MODE_DARKEN   = 3'd3,
        MODE_INVERT   = 3'd4,
        MODE_BOX_BLUR = 3'd5,
        MODE_EDGE     = 3'd6,
        MODE_SHARPEN  = 3'd7
    } filter_mode_e;

    typedef enum logic [0:0] {
        RUN     = 1'b0,
        PENDING = 1'b1
    } frame_state_e;

    typedef struct packed {
        pixel_t blue;
        pixel_t green;
        pixel_t red;
    } rgb_pixel_t;

    typedef struct packed {
        chan_out_t blue;
        chan_out_t green;
        chan_out_t red;
    } rgb_out_t;

    typedef struct packed {
        pixel_t center;
        pixel_t up;
        pixel_t down;
        pixel_t left;
        pixel_t right;
        pixel_t left_up;
        pixel_t left_down;
        pixel_t right_up;
        pixel_t right_down;
    } gray_window_t;

    typedef struct packed {
        coord_t hc;
        coord_t vc;
    } position_t;

    typedef struct packed {
        rgb_pixel_t result;
        logic       hit;
    } op_result_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
    } apb_rsp_t;

endpackage

// File: source/image_filter_top.sv
/*
  streaming pixel filter, two cycles from input pixel to output pixel
  no back-pressure, the 3x3 window comes from line buffers outside
*/
`timescale 1ns/100ps
`include "image_filter_params.svh"

module image_filter_top
    import image_filter_pkg::*;
#(
    parameter int line_pixels = `IMF_LINE_PIXELS,
    parameter int frame_lines = `IMF_FRAME_LINES
) (
    input  logic         clock,
    input  logic         reset,
    input  apb_req_t     apb_i,
    output apb_rsp_t     apb_o,
    input  logic         pixel_valid_i,
    input  rgb_pixel_t   pixel_i,
    input  gray_window_t window_i,
    output rgb_out_t     rgb_o,
    output position_t    position_o,
    output logic         out_valid_o
);

    position_t    position;
    logic         frame_end;
    filter_mode_e pending_mode;
    filter_mode_e active_mode;
    logic         mode_pending;
    logic         mode_applied;
    pixel_t       step;
    op_result_t   point_result;
    op_result_t   conv_result;

    ////////////////////////////////
    // control
    ////////////////////////////////

    apb_config_regs i_apb_config_regs (
        .clock          (clock),
        .reset          (reset),
        .apb_i          (apb_i),
        .apb_o          (apb_o),
        .mode_applied_i (mode_applied),
        .pending_mode_o (pending_mode),
        .mode_pending_o (mode_pending),
        .step_o         (step)
    );

    frame_mode_fsm i_frame_mode_fsm (
        .clock          (clock),
        .reset          (reset),
        .mode_pending_i (mode_pending),
        .pending_mode_i (pending_mode),
        .frame_end_i    (frame_end),
        .active_mode_o  (active_mode),
        .mode_applied_o (mode_applied)
    );

    pixel_position_counter #(
        .line_pixels (line_pixels),
        .frame_lines (frame_lines)
    ) i_pixel_position_counter (
        .clock         (clock),
        .reset         (reset),
        .pixel_valid_i (pixel_valid_i),
        .position_o    (position),
        .frame_end_o   (frame_end)
    );

    ////////////////////////////////
    // datapath
    ////////////////////////////////

    point_op_unit i_point_op_unit (
        .clock    (clock),
        .reset    (reset),
        .mode_i   (active_mode),
        .step_i   (step),
        .pixel_i  (pixel_i),
        .result_o (point_result)
    );

    window_conv_unit i_window_conv_unit (
        .clock    (clock),
        .reset    (reset),
        .mode_i   (active_mode),
        .window_i (window_i),
        .result_o (conv_result)
    );

    output_stage i_output_stage (
        .clock       (clock),
        .reset       (reset),
        .point_i     (point_result),
        .conv_i      (conv_result),
        .valid_i     (pixel_valid_i),
        .position_i  (position),
        .rgb_o       (rgb_o),
        .position_o  (position_o),
        .out_valid_o (out_valid_o)
    );

endmodule

// File: source/output_stage.sv
/*
  second pipeline stage, picks the result that hit and keeps the upper nibbles
  valid and position are delayed two cycles to line up with the colour
*/
`timescale 1ns/100ps

module output_stage
    import image_filter_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  op_result_t point_i,
    input  op_result_t conv_i,
    input  logic       valid_i,
    input  position_t  position_i,
    output rgb_out_t   rgb_o,
    output position_t  position_o,
    output logic       out_valid_o
);

    rgb_pixel_t selected;
    logic       valid_d1;
    position_t  position_d1;

    // the two hit bits never overlap
    assign selected = (point_i.hit ? point_i.result : rgb_pixel_t'(0))
                    | (conv_i.hit ? conv_i.result : rgb_pixel_t'(0));

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_d1    <= 1'b0;
            position_d1 <= '0;
            out_valid_o <= 1'b0;
            position_o  <= '0;
            rgb_o       <= '0;
        end else begin
            valid_d1    <= valid_i;
            position_d1 <= position_i;
            out_valid_o <= valid_d1;
            position_o  <= position_d1;
            // blanking gives black
            if (valid_d1) begin
                rgb_o.red   <= selected.red[`IMF_PIXEL_W-1 -: `IMF_OUT_W];
                rgb_o.green <= selected.green[`IMF_PIXEL_W-1 -: `IMF_OUT_W];
                rgb_o.blue  <= selected.blue[`IMF_PIXEL_W-1 -: `IMF_OUT_W];
            end else begin
                rgb_o <= '0;
            end
        end
    end

endmodule

// File: source/pixel_position_counter.sv
/*
  raster position of the pixel now at the input, from its own registers
  advances only on valid pixels, so blanking holds the position
*/
`timescale 1ns/100ps
`include "image_filter_params.svh"

module pixel_position_counter
    import image_filter_pkg::*;
#(
    parameter int line_pixels = `IMF_LINE_PIXELS,
    parameter int frame_lines = `IMF_FRAME_LINES
) (
    input  logic      clock,
    input  logic      reset,
    input  logic      pixel_valid_i,
    output position_t position_o,
    output logic      frame_end_o
);

    localparam coord_t last_col  = coord_t'(line_pixels - 1);
    localparam coord_t last_line = coord_t'(frame_lines - 1);

    coord_t hc;
    coord_t vc;

    assign position_o.hc = hc;
    assign position_o.vc = vc;
    assign frame_end_o   = pixel_valid_i && (hc == last_col) && (vc == last_line);

    always_ff @(posedge clock) begin
        if (reset) begin
            hc <= '0;
            vc <= '0;
        end else if (pixel_valid_i) begin
            if (hc == last_col) begin
                hc <= '0;
                // wrap to line 0 after the last line
                vc <= (vc == last_line) ? coord_t'(0) : vc + coord_t'(1);
            end else begin
                hc <= hc + coord_t'(1);
            end
        end
    end

endmodule

// File: source/point_op_unit.sv
/*
  per-pixel colour operations on the centre pixel, one register stage
  hit marks the point modes, other modes leave the result unused
*/
`timescale 1ns/100ps

module point_op_unit
    import image_filter_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  filter_mode_e mode_i,
    input  pixel_t       step_i,
    input  rgb_pixel_t   pixel_i,
    output op_result_t   result_o
);

    rgb_pixel_t result_nxt;
    pixel_t     gray;

    function automatic pixel_t sat_add(input pixel_t a, input pixel_t b);
        logic [`IMF_PIXEL_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[`IMF_PIXEL_W] ? '1 : sum[`IMF_PIXEL_W-1:0];
    endfunction

    function automatic pixel_t sat_sub(input pixel_t a, input pixel_t b);
        return (a < b) ? '0 : a - b;
    endfunction

    // luma approximation, peaks at 234
    assign gray = (pixel_i.red >> 2) + (pixel_i.red >> 5)
                + (pixel_i.green >> 1) + (pixel_i.green >> 4)
                + (pixel_i.blue >> 4) + (pixel_i.blue >> 5);

    always_comb begin
        result_nxt = pixel_i;
        case (mode_i)
            MODE_GRAY: begin
                result_nxt = '{blue: gray, green: gray, red: gray};
            end
            MODE_BRIGHTEN: begin
                result_nxt.red   = sat_add(pixel_i.red, step_i);
                result_nxt.green = sat_add(pixel_i.green, step_i);
                result_nxt.blue  = sat_add(pixel_i.blue, step_i);
            end
            MODE_DARKEN: begin
                result_nxt.red   = sat_sub(pixel_i.red, step_i);
                result_nxt.green = sat_sub(pixel_i.green, step_i);
                result_nxt.blue  = sat_sub(pixel_i.blue, step_i);
            end
            MODE_INVERT: begin
                result_nxt.red   = 8'd255 - pixel_i.red;
                result_nxt.green = 8'd255 - pixel_i.green;
                result_nxt.blue  = 8'd255 - pixel_i.blue;
            end
            default: result_nxt = pixel_i;
        endcase
    end

    always_ff @(posedge clock) begin
        result_o.result <= result_nxt;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result_o.hit <= 1'b0;
        end else begin
            result_o.hit <= (mode_i <= MODE_INVERT);
        end
    end

endmodule

// File: source/window_conv_unit.sv
/*
  3x3 grey-level convolutions, one register stage
  the grey result goes to all three channels
  edge and sharpen clamp to 0..255, box blur cannot leave that range
*/
`timescale 1ns/100ps

module window_conv_unit
    import image_filter_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  filter_mode_e mode_i,
    input  gray_window_t window_i,
    output op_result_t   result_o
);

    logic [11:0] box_sum;
    conv_sum_t   neigh_sum;
    conv_sum_t   cross_sum;
    conv_sum_t   edge_sum;
    conv_sum_t   sharp_sum;
    pixel_t      gray_nxt;

    function automatic pixel_t clamp_gray(input conv_sum_t s);
        if (s < 0) begin
            return '0;
        end else if (s > 13'sd255) begin
            return '1;
        end
        return s[`IMF_PIXEL_W-1:0];
    endfunction

    ////////////////////////////////
    // kernel sums
    ////////////////////////////////

    assign cross_sum = conv_sum_t'(window_i.up) + conv_sum_t'(window_i.down)
                     + conv_sum_t'(window_i.left) + conv_sum_t'(window_i.right);
    assign neigh_sum = cross_sum
                     + conv_sum_t'(window_i.left_up) + conv_sum_t'(window_i.left_down)
                     + conv_sum_t'(window_i.right_up) + conv_sum_t'(window_i.right_down);
    assign box_sum   = 12'(neigh_sum) + 12'(window_i.center);

    // 8c - neighbours and 5c - cross
    assign edge_sum  = (conv_sum_t'(window_i.center) <<< 3) - neigh_sum;
    assign sharp_sum = (conv_sum_t'(window_i.center) <<< 2)
                     + conv_sum_t'(window_i.center) - cross_sum;

    always_comb begin
        case (mode_i)
            MODE_BOX_BLUR: gray_nxt = pixel_t'(box_sum / 12'd9);
            MODE_EDGE:     gray_nxt = clamp_gray(edge_sum);
            MODE_SHARPEN:  gray_nxt = clamp_gray(sharp_sum);
            default:       gray_nxt = window_i.center;
        endcase
    end

    always_ff @(posedge clock) begin
        result_o.result <= '{blue: gray_nxt, green: gray_nxt, red: gray_nxt};
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result_o.hit <= 1'b0;
        end else begin
            result_o.hit <= (mode_i >= MODE_BOX_BLUR);
        end
    end

endmodule
